// File: hdl/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// mesh dimensions in routers.
`define MESH_SIZE_X 4
`define MESH_SIZE_Y 4

// coordinate field widths of a head flit.
`define DEST_ADDR_SIZE_X 2
`define DEST_ADDR_SIZE_Y 2

// virtual channels per port and the width of a vc id.
`define VC_NUM 2
`define VC_SIZE 1

// router ports, local port included.
`define PORT_NUM 5

// depth of each virtual-channel FIFO.
`define BUFFER_SIZE 8

// on_off goes low once free slots are at or below this value.
`define ON_OFF_THRESHOLD 3

`define PAYLOAD_SIZE 16

`endif

// File: hdl/noc_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    // output ports. Each encoding doubles as the port index.
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        SOUTH = 3'd2,
        EAST  = 3'd3,
        WEST  = 3'd4
    } port_t;

    typedef enum logic [1:0] {
        HEAD     = 2'b00,
        BODY     = 2'b01,
        TAIL     = 2'b10,
        HEADTAIL = 2'b11
    } flit_type_t;

    // destination fields are only meaningful in head flits.
    typedef struct packed {
        flit_type_t                   flit_type;
        logic [`VC_SIZE-1:0]          vc_id;
        logic [`DEST_ADDR_SIZE_X-1:0] x_dest;
        logic [`DEST_ADDR_SIZE_Y-1:0] y_dest;
        logic [`PAYLOAD_SIZE-1:0]     payload;
    } flit_t;

    // packet state seen from the write side of an input buffer.
    typedef enum logic {
        IDLE   = 1'b0,
        ROUTED = 1'b1
    } buf_state_t;

endpackage

`default_nettype wire

// File: hdl/rc_unit.sv
`default_nettype none

`include "noc_macros.svh"

module rc_unit
    import noc_pkg::*;
#(
    parameter int X_CURRENT = `MESH_SIZE_X/2,
    parameter int Y_CURRENT = `MESH_SIZE_Y/2
)(
    input  logic [`DEST_ADDR_SIZE_X-1:0] x_dest_i,
    input  logic [`DEST_ADDR_SIZE_Y-1:0] y_dest_i,
    output port_t                        out_port_o
);

    // dimension-order routing, x is resolved before y.
    // y grows toward the south edge of the mesh.
    always_comb
    begin
        if (int'(x_dest_i) > X_CURRENT)
            out_port_o = EAST;
        else if (int'(x_dest_i) < X_CURRENT)
            out_port_o = WEST;
        else if (int'(y_dest_i) > Y_CURRENT)
            out_port_o = SOUTH;
        else if (int'(y_dest_i) < Y_CURRENT)
            out_port_o = NORTH;
        else
            out_port_o = LOCAL;
    end

endmodule

`default_nettype wire

// File: hdl/input_buffer.sv
`default_nettype none

`include "noc_macros.svh"

module input_buffer
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  flit_t data_i,
    input  logic  write_i,
    input  logic  read_i,
    input  port_t out_port_i,
    output flit_t data_o,
    output logic  is_empty_o,
    output logic  on_off_o,
    output port_t out_port_o,
    output logic  is_tail_o
);

    localparam int PTR_W = $clog2(`BUFFER_SIZE);
    localparam int CNT_W = $clog2(`BUFFER_SIZE + 1);

    flit_t flit_mem [`BUFFER_SIZE];
    port_t port_mem [`BUFFER_SIZE];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_slots;

    buf_state_t state;
    port_t      route_q;
    port_t      wr_route;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`BUFFER_SIZE - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    // a flit written in IDLE opens a packet and takes the fresh route.
    assign wr_route = (state == IDLE) ? out_port_i : route_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state <= IDLE;
        end
        else if (write_i)
        begin
            case (state)
                IDLE:
                    if (data_i.flit_type == HEAD)
                        state <= ROUTED;
                ROUTED:
                    if (data_i.flit_type == TAIL)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_i && state == IDLE)
            route_q <= out_port_i;
    end

    // each entry keeps its own route, so a new head behind an older tail is safe.
    always_ff @(posedge clk)
    begin
        if (write_i)
        begin
            flit_mem[wr_ptr] <= data_i;
            port_mem[wr_ptr] <= wr_route;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (write_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (read_i)
                rd_ptr <= next_ptr(rd_ptr);
            if (write_i && !read_i)
                count <= count + 1'b1;
            else if (read_i && !write_i)
                count <= count - 1'b1;
        end
    end

    assign free_slots = CNT_W'(`BUFFER_SIZE) - count;
    assign on_off_o   = free_slots > CNT_W'(`ON_OFF_THRESHOLD);
    assign is_empty_o = count == '0;
    assign data_o     = flit_mem[rd_ptr];
    assign out_port_o = port_mem[rd_ptr];
    assign is_tail_o  = data_o.flit_type == TAIL || data_o.flit_type == HEADTAIL;

    // upstream must honour on_off early enough to never hit a full buffer.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        write_i |-> count != CNT_W'(`BUFFER_SIZE))
        else $error("input_buffer: write while full");

    // the allocator only grants a vc that holds a flit.
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        read_i |-> !is_empty_o)
        else $error("input_buffer: read while empty");

endmodule

`default_nettype wire

// File: hdl/input_port.sv
`default_nettype none

`include "noc_macros.svh"

module input_port
    import noc_pkg::*;
#(
    parameter int X_CURRENT = `MESH_SIZE_X/2,
    parameter int Y_CURRENT = `MESH_SIZE_Y/2
)(
    input  logic                clk,
    input  logic                rst_n_i,
    input  flit_t               data_i,
    input  logic                valid_flit_i,
    input  logic [`VC_SIZE-1:0] vc_sel_i,
    input  logic                read_i,
    output flit_t               flit_o,
    output logic [`VC_NUM-1:0]  on_off_o,
    output logic [`VC_NUM-1:0]  is_empty_o,
    output logic [`VC_NUM-1:0]  is_tail_o,
    output port_t [`VC_NUM-1:0] out_port_o
);

    flit_t [`VC_NUM-1:0] data;
    flit_t               in_flit_q;
    logic                in_valid_q;
    port_t               out_port_cmd;
    logic [`VC_NUM-1:0]  write_cmd;
    logic [`VC_NUM-1:0]  read_cmd;

    // arriving flits are staged one cycle before they enter a buffer.
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            in_valid_q <= 1'b0;
        else
            in_valid_q <= valid_flit_i;
    end

    always_ff @(posedge clk)
    begin
        in_flit_q <= data_i;
    end

    for (genvar vc = 0; vc < `VC_NUM; vc++)
    begin : g_virtual_channels
        input_buffer input_buffer_inst (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .data_i     (in_flit_q),
            .write_i    (write_cmd[vc]),
            .read_i     (read_cmd[vc]),
            .out_port_i (out_port_cmd),
            .data_o     (data[vc]),
            .is_empty_o (is_empty_o[vc]),
            .on_off_o   (on_off_o[vc]),
            .out_port_o (out_port_o[vc]),
            .is_tail_o  (is_tail_o[vc])
        );
    end

    // the route is only latched for heads, so body flits may feed it garbage.
    rc_unit #(
        .X_CURRENT (X_CURRENT),
        .Y_CURRENT (Y_CURRENT)
    ) rc_unit_inst (
        .x_dest_i   (in_flit_q.x_dest),
        .y_dest_i   (in_flit_q.y_dest),
        .out_port_o (out_port_cmd)
    );

    always_comb
    begin
        write_cmd = '0;
        if (in_valid_q)
            write_cmd[in_flit_q.vc_id] = 1'b1;

        read_cmd = '0;
        read_cmd[vc_sel_i] = read_i;
        flit_o = data[vc_sel_i];
    end

endmodule

`default_nettype wire

// File: hdl/switch_allocator.sv
`default_nettype none

`include "noc_macros.svh"

module switch_allocator
    import noc_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [`PORT_NUM-1:0][`VC_NUM-1:0]   is_empty_i,
    input  logic [`PORT_NUM-1:0][`VC_NUM-1:0]   is_tail_i,
    input  port_t [`PORT_NUM-1:0][`VC_NUM-1:0]  out_port_i,
    input  logic [`PORT_NUM-1:0][`VC_NUM-1:0]   on_off_i,
    output logic [`PORT_NUM-1:0]                grant_valid_o,
    output logic [`PORT_NUM-1:0][`VC_SIZE-1:0]  vc_sel_o,
    output logic [`PORT_NUM-1:0]                out_valid_o,
    output port_t [`PORT_NUM-1:0]               in_sel_o
);

    localparam int PORT_W = $clog2(`PORT_NUM);

    // wormhole lock of each output.
    logic [`PORT_NUM-1:0]               lock_valid;
    logic [`PORT_NUM-1:0][PORT_W-1:0]   lock_in;
    logic [`PORT_NUM-1:0][`VC_SIZE-1:0] lock_vc;

    logic [`PORT_NUM-1:0][`VC_SIZE-1:0] vc_ptr;
    logic [`PORT_NUM-1:0][PORT_W-1:0]   in_ptr;

    logic [`PORT_NUM-1:0]                cand_valid;
    logic [`PORT_NUM-1:0][`VC_SIZE-1:0]  cand_vc;
    port_t [`PORT_NUM-1:0]               cand_port;
    logic [`PORT_NUM-1:0]                cand_tail;
    logic [`PORT_NUM-1:0][`PORT_NUM-1:0] gnt;
    logic [`PORT_NUM-1:0][`PORT_NUM-1:0] sel_by;

    // per input, one vc whose output is reachable and not blocked downstream.
    always_comb
    begin
        int    v;
        port_t o;
        v = 0;
        o = LOCAL;
        for (int i = 0; i < `PORT_NUM; i++)
        begin
            cand_valid[i] = 1'b0;
            cand_vc[i]    = '0;
            cand_port[i]  = LOCAL;
            cand_tail[i]  = 1'b0;
            for (int k = 0; k < `VC_NUM; k++)
            begin
                v = (int'(vc_ptr[i]) + k) % `VC_NUM;
                o = out_port_i[i][v];
                if (!cand_valid[i] && !is_empty_i[i][v] && on_off_i[o][v] &&
                    (!lock_valid[o] || (lock_in[o] == i && lock_vc[o] == v)))
                begin
                    cand_valid[i] = 1'b1;
                    cand_vc[i]    = `VC_SIZE'(v);
                    cand_port[i]  = o;
                    cand_tail[i]  = is_tail_i[i][v];
                end
            end
        end
    end

    // per output, round robin over the requesting inputs. gnt is [output][input].
    always_comb
    begin
        int i;
        i = 0;
        gnt = '0;
        for (int o = 0; o < `PORT_NUM; o++)
        begin
            for (int k = 0; k < `PORT_NUM; k++)
            begin
                i = (int'(in_ptr[o]) + k) % `PORT_NUM;
                if (gnt[o] == '0 && cand_valid[i] && cand_port[i] == o)
                    gnt[o][i] = 1'b1;
            end
        end
    end

    always_comb
    begin
        for (int o = 0; o < `PORT_NUM; o++)
        begin
            out_valid_o[o] = |gnt[o];
            in_sel_o[o]    = LOCAL;
            for (int i = 0; i < `PORT_NUM; i++)
                if (gnt[o][i])
                    in_sel_o[o] = port_t'(i);
        end
        for (int i = 0; i < `PORT_NUM; i++)
        begin
            grant_valid_o[i] = 1'b0;
            for (int o = 0; o < `PORT_NUM; o++)
                grant_valid_o[i] = grant_valid_o[i] | gnt[o][i];
        end
    end

    assign vc_sel_o = cand_vc;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            lock_valid <= '0;
            lock_in    <= '0;
            lock_vc    <= '0;
            in_ptr     <= '0;
            vc_ptr     <= '0;
        end
        else
        begin
            for (int o = 0; o < `PORT_NUM; o++)
            begin
                if (out_valid_o[o])
                begin
                    in_ptr[o]     <= PORT_W'((int'(in_sel_o[o]) + 1) % `PORT_NUM);
                    // a tail releases the output, anything else holds it.
                    lock_valid[o] <= !cand_tail[in_sel_o[o]];
                    lock_in[o]    <= PORT_W'(in_sel_o[o]);
                    lock_vc[o]    <= cand_vc[in_sel_o[o]];
                end
            end
            for (int i = 0; i < `PORT_NUM; i++)
                if (grant_valid_o[i])
                    vc_ptr[i] <= `VC_SIZE'((int'(cand_vc[i]) + 1) % `VC_NUM);
        end
    end

    // sel_by is [input][output].
    always_comb
    begin
        for (int i = 0; i < `PORT_NUM; i++)
            for (int o = 0; o < `PORT_NUM; o++)
                sel_by[i][o] = out_valid_o[o] && in_sel_o[o] == i;
    end

    for (genvar i = 0; i < `PORT_NUM; i++)
    begin : g_select_check
        a_one_output: assert property (@(posedge clk) disable iff (!rst_n_i)
            $onehot0(sel_by[i]))
            else $error("switch_allocator: input %0d selected by several outputs", i);
    end

endmodule

`default_nettype wire

// File: hdl/crossbar.sv
`default_nettype none

`include "noc_macros.svh"

module crossbar
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  flit_t [`PORT_NUM-1:0] flit_i,
    input  port_t [`PORT_NUM-1:0] in_sel_i,
    input  logic  [`PORT_NUM-1:0] out_valid_i,
    output flit_t [`PORT_NUM-1:0] flit_o,
    output logic  [`PORT_NUM-1:0] valid_o
);

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            valid_o <= '0;
        else
            valid_o <= out_valid_i;
    end

    // an idle output keeps its last flit, valid_o tells it apart.
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < `PORT_NUM; o++)
        begin
            if (out_valid_i[o])
                flit_o[o] <= flit_i[in_sel_i[o]];
        end
    end

endmodule

`default_nettype wire

// File: hdl/router.sv
`default_nettype none

`include "noc_macros.svh"

module router
    import noc_pkg::*;
#(
    parameter int X_CURRENT = `MESH_SIZE_X/2,
    parameter int Y_CURRENT = `MESH_SIZE_Y/2
)(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  flit_t [`PORT_NUM-1:0]             flit_i,
    input  logic  [`PORT_NUM-1:0]             valid_i,
    input  logic  [`PORT_NUM-1:0][`VC_NUM-1:0] on_off_i,
    output flit_t [`PORT_NUM-1:0]             flit_o,
    output logic  [`PORT_NUM-1:0]             valid_o,
    output logic  [`PORT_NUM-1:0][`VC_NUM-1:0] on_off_o
);

    flit_t [`PORT_NUM-1:0]               port_flit;
    logic  [`PORT_NUM-1:0][`VC_NUM-1:0]  is_empty;
    logic  [`PORT_NUM-1:0][`VC_NUM-1:0]  is_tail;
    port_t [`PORT_NUM-1:0][`VC_NUM-1:0]  out_port;
    logic  [`PORT_NUM-1:0]               grant_valid;
    logic  [`PORT_NUM-1:0][`VC_SIZE-1:0] vc_sel;
    logic  [`PORT_NUM-1:0]               out_valid;
    port_t [`PORT_NUM-1:0]               in_sel;

    for (genvar p = 0; p < `PORT_NUM; p++)
    begin : g_input_ports
        input_port #(
            .X_CURRENT (X_CURRENT),
            .Y_CURRENT (Y_CURRENT)
        ) input_port_inst (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .data_i       (flit_i[p]),
            .valid_flit_i (valid_i[p]),
            .vc_sel_i     (vc_sel[p]),
            .read_i       (grant_valid[p]),
            .flit_o       (port_flit[p]),
            .on_off_o     (on_off_o[p]),
            .is_empty_o   (is_empty[p]),
            .is_tail_o    (is_tail[p]),
            .out_port_o   (out_port[p])
        );
    end

    switch_allocator switch_allocator_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .is_empty_i    (is_empty),
        .is_tail_i     (is_tail),
        .out_port_i    (out_port),
        .on_off_i      (on_off_i),
        .grant_valid_o (grant_valid),
        .vc_sel_o      (vc_sel),
        .out_valid_o   (out_valid),
        .in_sel_o      (in_sel)
    );

    crossbar crossbar_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flit_i      (port_flit),
        .in_sel_i    (in_sel),
        .out_valid_i (out_valid),
        .flit_o      (flit_o),
        .valid_o     (valid_o)
    );

endmodule

`default_nettype wire

// File: sim/router_tb.sv
`default_nettype none

`include "noc_macros.svh"

module router_tb
    import noc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int X_NODE = 1;
    localparam int Y_NODE = 2;

    logic                              clk;
    logic                              rst_n;
    flit_t [`PORT_NUM-1:0]             flit_in;
    logic  [`PORT_NUM-1:0]             valid_in;
    logic  [`PORT_NUM-1:0][`VC_NUM-1:0] on_off_dn;
    flit_t [`PORT_NUM-1:0]             flit_out;
    logic  [`PORT_NUM-1:0]             valid_out;
    logic  [`PORT_NUM-1:0][`VC_NUM-1:0] on_off_up;
    logic  [`PORT_NUM-1:0][`VC_NUM-1:0] on_off_q;

    integer seed = 32'hdafa5ea1;

    // expected {port, flit} per input and vc, indexed by {src, vc}.
    logic [25:0] exp_q [2*`PORT_NUM][$];
    int          flits_in = 0;
    int          flits_out = 0;
    int          check_errs = 0;
    int          timeout_errs = 0;
    int          fill_sent = 0;
    logic        injected = 1'b0;
    logic        lat_chk = 1'b0;
    logic [1:0]  lat_seen = 2'b00;

    // packet in progress on each input.
    int                  pkt_len [`PORT_NUM];
    int                  pkt_left [`PORT_NUM];
    logic [`VC_SIZE-1:0] pkt_vc [`PORT_NUM];
    logic [1:0]          pkt_x [`PORT_NUM];
    logic [1:0]          pkt_y [`PORT_NUM];

    // last delivered flit of each output and what was made of it.
    logic [`PORT_NUM-1:0] chk = '0;
    logic [`PORT_NUM-1:0] found;
    logic [`PORT_NUM-1:0] lock_ok;
    logic [`PORT_NUM-1:0] onoff_ok;
    logic [`PORT_NUM-1:0] pkt_open;
    flit_t                got_flit [`PORT_NUM];
    flit_t                exp_flit [`PORT_NUM];
    logic [2:0]           exp_port [`PORT_NUM];
    logic [`VC_NUM-1:0]   got_onoff [`PORT_NUM];
    logic [3:0]           owner [`PORT_NUM];

    router #(
        .X_CURRENT (X_NODE),
        .Y_CURRENT (Y_NODE)
    ) router_inst (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .flit_i   (flit_in),
        .valid_i  (valid_in),
        .on_off_i (on_off_dn),
        .flit_o   (flit_out),
        .valid_o  (valid_out),
        .on_off_o (on_off_up)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the allocator sees on_off_i one cycle before its flit shows up.
    always @(posedge clk)
        on_off_q <= on_off_dn;

    // xy routing, y grows toward the south.
    function automatic logic [2:0] xy_route(input logic [1:0] x, input logic [1:0] y);
        if (int'(x) > X_NODE)
            return EAST;
        else if (int'(x) < X_NODE)
            return WEST;
        else if (int'(y) > Y_NODE)
            return SOUTH;
        else if (int'(y) < Y_NODE)
            return NORTH;
        return LOCAL;
    endfunction

    function automatic flit_t make_flit(input int p);
        flit_t f;
        f.vc_id  = pkt_vc[p];
        f.x_dest = pkt_x[p];
        f.y_dest = pkt_y[p];
        if (pkt_len[p] == 1)
            f.flit_type = HEADTAIL;
        else if (pkt_left[p] == pkt_len[p])
            f.flit_type = HEAD;
        else if (pkt_left[p] == 1)
            f.flit_type = TAIL;
        else
            f.flit_type = BODY;
        // top payload bits name the source input.
        f.payload = {3'(p), 13'($random(seed))};
        return f;
    endfunction

    task automatic start_packet(input int p, input logic vc, input logic [1:0] x,
                                input logic [1:0] y, input int len);
        pkt_vc[p]   = vc;
        pkt_x[p]    = x;
        pkt_y[p]    = y;
        pkt_len[p]  = len;
        pkt_left[p] = len;
    endtask

    task automatic send_flit(input int p);
        flit_t f;
        f = make_flit(p);
        flit_in[p]  = f;
        valid_in[p] = 1'b1;
        exp_q[p*`VC_NUM + int'(f.vc_id)].push_back({xy_route(f.x_dest, f.y_dest), f});
        pkt_left[p]--;
        flits_in++;
        injected = 1'b1;
    endtask

    function automatic logic busy();
        for (int p = 0; p < `PORT_NUM; p++)
            if (pkt_left[p] > 0)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic step_ports(input bit allow_start);
        int r;
        int len;
        for (int p = 0; p < `PORT_NUM; p++)
        begin
            valid_in[p] = 1'b0;
            r = $random(seed);
            len = (r[10:8] < 3'd5) ? int'(r[10:8]) + 1 : 1;
            if (allow_start && pkt_left[p] == 0 && r[1:0] == 2'b00)
                start_packet(p, r[2], r[4:3], r[6:5], len);
            // random gaps, and only while the vc is open.
            if (pkt_left[p] > 0 && r[13:11] != 3'b000 && on_off_up[p][pkt_vc[p]])
                send_flit(p);
        end
    endtask

    task automatic toggle_downstream();
        int r;
        r = $random(seed);
        for (int b = 0; b < `PORT_NUM*`VC_NUM; b++)
            if (r[3*b +: 3] == 3'b000)
                on_off_dn[b / `VC_NUM][b % `VC_NUM] = ~on_off_dn[b / `VC_NUM][b % `VC_NUM];
    endtask

    task automatic run_random(input int cycles, input bit toggle);
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk);
            step_ports(1'b1);
            if (toggle)
                toggle_downstream();
        end
    endtask

    task automatic finish_packets(input int limit);
        int n;
        n = 0;
        on_off_dn = '1;
        while (busy() && n < limit)
        begin
            @(negedge clk);
            step_ports(1'b0);
            n++;
        end
        @(negedge clk);
        valid_in = '0;
        if (busy())
        begin
            timeout_errs++;
            $display("timed out while finishing the open packets");
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (flits_out != flits_in && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (flits_out != flits_in)
        begin
            timeout_errs++;
            $display("timed out with %0d of %0d flits still inside the router",
                     flits_in - flits_out, flits_in);
        end
    endtask

    // one headtail flit from LOCAL to NORTH through an idle router.
    task automatic measure_latency();
        logic early;
        @(negedge clk);
        start_packet(LOCAL, 1'b0, 2'(X_NODE), 2'd0, 1);
        send_flit(LOCAL);
        @(negedge clk);
        valid_in = '0;
        @(negedge clk);
        early = valid_out[NORTH];
        @(negedge clk);
        lat_seen = {early, valid_out[NORTH]};
        lat_chk  = 1'b1;
        @(negedge clk);
        lat_chk  = 1'b0;
    endtask

    // WEST vc 1 keeps sending toward a blocked EAST vc 1.
    task automatic fill_buffer();
        int n;
        n = 0;
        @(negedge clk);
        on_off_dn[EAST][1] = 1'b0;
        while (on_off_up[WEST][1] && fill_sent < `BUFFER_SIZE && n < 4*`BUFFER_SIZE)
        begin
            start_packet(WEST, 1'b1, 2'd3, 2'(Y_NODE), 1);
            send_flit(WEST);
            fill_sent++;
            @(negedge clk);
            valid_in = '0;
            n++;
        end
        if (on_off_up[WEST][1])
        begin
            timeout_errs++;
            $display("on_off_o of input WEST vc 1 never dropped while its output was blocked");
        end
        repeat (4) @(negedge clk);
        on_off_dn[EAST][1] = 1'b1;
    endtask

    always @(negedge clk)
    begin : observe_outputs
        flit_t       f;
        logic [3:0]  src_vc;
        logic [25:0] e;
        for (int o = 0; o < `PORT_NUM; o++)
        begin
            chk[o] = rst_n && valid_out[o];
            if (!rst_n)
                pkt_open[o] = 1'b0;
            if (chk[o])
            begin
                f = flit_out[o];
                src_vc = {f.payload[15:13], f.vc_id};
                got_flit[o]  = f;
                got_onoff[o] = on_off_q[o];
                onoff_ok[o]  = on_off_q[o][f.vc_id];
                found[o]     = 1'b0;
                if (int'(src_vc) < 2*`PORT_NUM && exp_q[src_vc].size() > 0)
                begin
                    e = exp_q[src_vc].pop_front();
                    found[o]    = 1'b1;
                    exp_port[o] = e[25:23];
                    exp_flit[o] = e[22:0];
                end
                if (pkt_open[o])
                    lock_ok[o] = owner[o] == src_vc &&
                                 (f.flit_type == BODY || f.flit_type == TAIL);
                else
                    lock_ok[o] = f.flit_type == HEAD || f.flit_type == HEADTAIL;
                if (f.flit_type == HEAD)
                begin
                    pkt_open[o] = 1'b1;
                    owner[o]    = src_vc;
                end
                else if (f.flit_type == TAIL)
                    pkt_open[o] = 1'b0;
                flits_out++;
            end
        end
    end

    for (genvar o = 0; o < `PORT_NUM; o++)
    begin : g_output_checks
        a_known: assert property (@(posedge clk) disable iff (!rst_n) chk[o] |-> found[o])
            else
            begin
                check_errs++;
                $display("output %0d delivered a flit that was never injected", o);
            end

        a_route: assert property (@(posedge clk) disable iff (!rst_n)
            (chk[o] && found[o]) |-> exp_port[o] == o)
            else
            begin
                check_errs++;
                $display("[FAIL] flit_o port got %h exp %h", 3'(o), exp_port[o]);
            end

        a_flit: assert property (@(posedge clk) disable iff (!rst_n)
            (chk[o] && found[o]) |-> got_flit[o] == exp_flit[o])
            else
            begin
                check_errs++;
                $display("[FAIL] flit_o[%0d] got %h exp %h", o, got_flit[o], exp_flit[o]);
            end

        a_lock: assert property (@(posedge clk) disable iff (!rst_n) chk[o] |-> lock_ok[o])
            else
            begin
                check_errs++;
                $display("[FAIL] flit_o[%0d] type %h src/vc %h inside packet of src/vc %h",
                         o, got_flit[o].flit_type, {got_flit[o].payload[15:13],
                         got_flit[o].vc_id}, owner[o]);
            end

        a_onoff: assert property (@(posedge clk) disable iff (!rst_n) chk[o] |-> onoff_ok[o])
            else
            begin
                check_errs++;
                $display("[FAIL] flit_o[%0d] vc %h sent while on_off_i was %h",
                         o, got_flit[o].vc_id, got_onoff[o]);
            end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !injected |-> (valid_out == '0 && on_off_up == '1))
        else
        begin
            check_errs++;
            $display("[FAIL] before injection valid_o %h exp 00, on_off_o %h exp 3ff",
                     valid_out, on_off_up);
        end

    a_fill: assert property (@(posedge clk) disable iff (!rst_n) fill_sent < `BUFFER_SIZE)
        else
        begin
            check_errs++;
            $display("[FAIL] fill_sent got %h, on_off_o must drop below %h", fill_sent,
                     `BUFFER_SIZE);
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        lat_chk |-> lat_seen == 2'b01)
        else
        begin
            check_errs++;
            $display("[FAIL] valid_o[1] at cycles 1 and 2 got %h exp 1", lat_seen);
        end

    initial
    begin
        rst_n     = 1'b0;
        flit_in   = '0;
        valid_in  = '0;
        on_off_dn = '1;
        for (int p = 0; p < `PORT_NUM; p++)
        begin
            pkt_len[p]  = 0;
            pkt_left[p] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        measure_latency();
        wait_drain(50);
        run_random(300, 1'b0);
        finish_packets(200);
        wait_drain(200);
        run_random(400, 1'b1);
        finish_packets(400);
        wait_drain(400);
        fill_buffer();
        wait_drain(100);
        @(negedge clk);

        $display("errors: %0d check, %0d timeout; flits in %0d, out %0d",
                 check_errs, timeout_errs, flits_in, flits_out);
        if (check_errs == 0 && timeout_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/rc_unit.sv
hdl/input_buffer.sv
hdl/input_port.sv
hdl/switch_allocator.sv
hdl/crossbar.sv
hdl/router.sv
sim/router_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module router_tb -f tb.f -Mdir obj_dir

./obj_dir/Vrouter_tb | tee sim.log

if grep -qF '** PASS **' sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
